//--- Makefile
SOURCES := $(shell cat all.f)

.PHONY: run clean

run: obj_dir/VfpMacUnit_tb
	./obj_dir/VfpMacUnit_tb | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

obj_dir/VfpMacUnit_tb: all.f $(SOURCES)
	verilator --binary --timing --assert --top-module fpMacUnit_tb \
		-Mdir obj_dir -f all.f

clean:
	rm -rf obj_dir sim.log

//--- all.f
hw/fpFormatPkg.sv
hw/macCtrlPkg.sv
hw/fpOperandIf.sv
hw/fpDelayLine.sv
hw/fpLaneUnpack.sv
hw/fpMultiply.sv
hw/fpAlignAdd.sv
hw/fpLanePack.sv
hw/fpMacUnit.sv
testbench/fpMacUnit_checker.sv
testbench/fpMacUnit_tb.sv

//--- hw/fpAlignAdd.sv
`timescale 1ns/1ps
`default_nettype none

module fpAlignAdd (
	input logic clock,
	input logic rst,
	input logic hold,
	fpOperandIf.consumer prod,
	fpOperandIf.consumer addend,
	input macCtrlPkg::macTagT tagIn,
	output logic sumValid,
	output fpFormatPkg::fpUnpackedT sum,
	output macCtrlPkg::macTagT tagOut
);
	import fpFormatPkg::*;
	import macCtrlPkg::*;

	logic addSign;
	logic signed [15:0] addExp;
	logic [71:0] addFrac;
	logic signed [15:0] prodExp;
	logic signed [15:0] expMax;

	logic signP1, signU1;
	logic [15:0] expC1;
	logic [15:0] shiftP1, shiftU1;
	logic [71:0] fracP1, fracU1;

	logic signP2, signU2;
	logic [15:0] expC2;
	logic [71:0] fracP2, fracU2;

	logic signed [73:0] termP, termU, total;
	logic [72:0] magnitude;

	// tag line doubles as the valid pipeline of the three stages
	fpDelayLine #(.depth(3), .payloadType(macTagT)) tagLine (
		.clock(clock),
		.rst(rst),
		.hold(hold),
		.inValid(prod.valid && addend.valid),
		.inData(tagIn),
		.outValid(sumValid),
		.outData(tagOut)
	);

	always_comb
	begin
		prodExp = $signed(prod.data.exp);
		addSign = addend.data.sign ^ (tagIn.op == opMulSub);
		addExp = $signed(addend.data.exp);
		addFrac = addend.data.frac;
		if (tagIn.op == opMul)
		begin
			addExp = prodExp; // no shift on the product
			addFrac = '0;
		end
		expMax = (prodExp > addExp) ? prodExp : addExp;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			// stage one: exponent compare
			signP1 <= prod.data.sign;
			signU1 <= addSign;
			expC1 <= expMax;
			shiftP1 <= expMax - prodExp;
			shiftU1 <= expMax - addExp;
			fracP1 <= prod.data.frac;
			fracU1 <= addFrac;
			// stage two: smaller side shifted right, large gaps drain to zero
			signP2 <= signP1;
			signU2 <= signU1;
			expC2 <= expC1;
			fracP2 <= fracP1 >> shiftP1;
			fracU2 <= fracU1 >> shiftU1;
		end
	end

	always_comb
	begin
		termP = signP2 ? -$signed({2'b00, fracP2}) : $signed({2'b00, fracP2});
		termU = signU2 ? -$signed({2'b00, fracU2}) : $signed({2'b00, fracU2});
		total = termP + termU;
		magnitude = total[73] ? 73'(-total) : 73'(total);
	end

	// stage three: carry out of bit 71 folds back into the exponent
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			sum.sign <= total[73];
			sum.exp <= magnitude[72] ? expC2 + 16'd1 : expC2;
			sum.frac <= magnitude[72] ? magnitude[72:1] : magnitude[71:0];
		end
	end

endmodule

`default_nettype wire

//--- hw/fpDelayLine.sv
`timescale 1ns/1ps
`default_nettype none

module fpDelayLine #(
	parameter int depth = 2,
	parameter type payloadType = logic
) (
	input logic clock,
	input logic rst,
	input logic hold,
	input logic inValid,
	input payloadType inData,
	output logic outValid,
	output payloadType outData
);

	logic [depth-1:0] validQ;
	payloadType dataQ [depth];

	always_ff @(posedge clock)
	begin
		if (rst)
			validQ <= '0;
		else if (!hold)
		begin
			validQ[0] <= inValid;
			for (int i = 1; i < depth; i++)
				validQ[i] <= validQ[i-1];
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			dataQ[0] <= inData;
			for (int i = 1; i < depth; i++)
				dataQ[i] <= dataQ[i-1];
		end
	end

	assign outValid = validQ[depth-1];
	assign outData = dataQ[depth-1];

endmodule

`default_nettype wire

//--- hw/fpFormatPkg.sv
`default_nettype none

package fpFormatPkg;

	// binary32 field layout
	localparam int fracBits = 23;
	localparam int expBits = 8;
	localparam int expBias = 127;
	localparam int expMaxFinite = 254;

	// wide datapath form
	localparam int wideExpBits = 16;
	localparam int wideFracBits = 72;
	localparam int hiddenPos = 70; // bit 71 catches product carry

	typedef logic [31:0] fpBits32T;

	// exponent is treated as signed inside the datapath
	typedef struct packed
	{
		logic sign;
		logic [wideExpBits-1:0] exp;
		logic [wideFracBits-1:0] frac;
	} fpUnpackedT;

endpackage

`default_nettype wire

//--- hw/fpLanePack.sv
`timescale 1ns/1ps
`default_nettype none

module fpLanePack #(
	parameter int laneCount = 4
) (
	input logic clock,
	input logic rst,
	input logic hold,
	input logic sumValid,
	input fpFormatPkg::fpUnpackedT sum,
	input macCtrlPkg::macTagT tag,
	output logic resultValid,
	output macCtrlPkg::vecT result
);
	import fpFormatPkg::*;
	import macCtrlPkg::*;

	int lead;
	int expN;
	logic [71:0] norm;
	fpBits32T laneWord;
	vecT merged;

	always_comb
	begin
		lead = 0;
		for (int i = 0; i < wideFracBits; i++)
			if (sum.frac[i])
				lead = i; // highest set bit wins
		expN = int'($signed(sum.exp)) + lead - hiddenPos;
		if (lead == 71)
			norm = sum.frac >> 1;
		else
			norm = sum.frac << (hiddenPos - lead);

		// low fraction bits just drop, i.e. round toward zero
		if (sum.frac == '0 || expN < 1)
			laneWord = {sum.sign, 31'b0};
		else if (expN > expMaxFinite)
			laneWord = {sum.sign, 8'hff, 23'b0};
		else
			laneWord = {sum.sign, expN[7:0], norm[69:47]};

		merged = tag.srcM;
		if (int'(tag.laneDst) < laneCount)
			merged[tag.laneDst] = laneWord;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			resultValid <= 1'b0;
		else if (!hold)
			resultValid <= sumValid;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			result <= merged;
	end

endmodule

`default_nettype wire

//--- hw/fpLaneUnpack.sv
`timescale 1ns/1ps
`default_nettype none

module fpLaneUnpack #(
	parameter int laneCount = 4
) (
	input logic clock,
	input logic rst,
	input logic hold,
	input macCtrlPkg::vecT src,
	input macCtrlPkg::laneIdxT laneSel,
	input logic inValid,
	fpOperandIf.producer out
);
	import fpFormatPkg::*;

	fpBits32T lane;
	fpUnpackedT unpacked;

	always_comb
	begin
		lane = '0; // lanes past laneCount read as zero
		if (int'(laneSel) < laneCount)
			lane = src[laneSel];
		unpacked.sign = lane[31];
		if (lane[30:23] == '0)
		begin
			// zero and denormal both land here
			unpacked.exp = '0;
			unpacked.frac = '0;
		end
		else
		begin
			unpacked.exp = {8'b0, lane[30:23]};
			unpacked.frac = {1'b0, 1'b1, lane[22:0], 47'b0};
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			out.valid <= 1'b0;
		else if (!hold)
			out.valid <= inValid;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			out.data <= unpacked;
	end

endmodule

`default_nettype wire

//--- hw/fpMacUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fpMacUnit #(
	parameter int laneCount = 4
) (
	input logic clock,
	input logic rst,
	input logic hold,
	input logic inValid,
	input macCtrlPkg::macOpT macOp,
	input macCtrlPkg::laneIdxT laneSel,
	input macCtrlPkg::laneIdxT laneDst,
	input macCtrlPkg::vecT srcS,
	input macCtrlPkg::vecT srcT,
	input macCtrlPkg::vecT srcU,
	input macCtrlPkg::vecT srcM,
	output logic resultValid,
	output macCtrlPkg::vecT result
);
	import fpFormatPkg::*;
	import macCtrlPkg::*;

	fpOperandIf opS ();
	fpOperandIf opT ();
	fpOperandIf opU ();
	fpOperandIf product ();
	fpOperandIf addend ();

	macTagT issueTag; // lines up with the unpacked operands
	macTagT mulTag;
	macTagT packTag;
	logic sumValid;
	fpUnpackedT sum;

	always_ff @(posedge clock)
	begin
		if (!hold)
			issueTag <= '{op: macOp, laneDst: laneDst, srcM: srcM};
	end

	fpLaneUnpack #(.laneCount(laneCount)) unpackS (
		.clock(clock), .rst(rst), .hold(hold),
		.src(srcS), .laneSel(laneSel), .inValid(inValid), .out(opS)
	);

	fpLaneUnpack #(.laneCount(laneCount)) unpackT (
		.clock(clock), .rst(rst), .hold(hold),
		.src(srcT), .laneSel(laneSel), .inValid(inValid), .out(opT)
	);

	fpLaneUnpack #(.laneCount(laneCount)) unpackU (
		.clock(clock), .rst(rst), .hold(hold),
		.src(srcU), .laneSel(laneSel), .inValid(inValid), .out(opU)
	);

	fpMultiply mul (
		.clock(clock), .rst(rst), .hold(hold),
		.a(opS), .b(opT), .prod(product)
	);

	// both lines match the two multiplier stages
	fpDelayLine #(.depth(2), .payloadType(fpUnpackedT)) addendLine (
		.clock(clock), .rst(rst), .hold(hold),
		.inValid(opU.valid), .inData(opU.data),
		.outValid(addend.valid), .outData(addend.data)
	);

	fpDelayLine #(.depth(2), .payloadType(macTagT)) tagLine (
		.clock(clock), .rst(rst), .hold(hold),
		.inValid(opU.valid), .inData(issueTag),
		.outValid(), .outData(mulTag)
	);

	fpAlignAdd alignAdd (
		.clock(clock), .rst(rst), .hold(hold),
		.prod(product), .addend(addend), .tagIn(mulTag),
		.sumValid(sumValid), .sum(sum), .tagOut(packTag)
	);

	fpLanePack #(.laneCount(laneCount)) pack (
		.clock(clock), .rst(rst), .hold(hold),
		.sumValid(sumValid), .sum(sum), .tag(packTag),
		.resultValid(resultValid), .result(result)
	);

endmodule

`default_nettype wire

//--- hw/fpMultiply.sv
`timescale 1ns/1ps
`default_nettype none

module fpMultiply (
	input logic clock,
	input logic rst,
	input logic hold,
	fpOperandIf.consumer a,
	fpOperandIf.consumer b,
	fpOperandIf.producer prod
);
	import fpFormatPkg::*;

	logic valid1;
	logic sign1;
	logic [15:0] exp1;
	logic zero1;
	logic [23:0] fracA1; // significands incl. hidden bit
	logic [23:0] fracB1;
	logic [47:0] product;

	assign product = fracA1 * fracB1;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			valid1 <= 1'b0;
			prod.valid <= 1'b0;
		end
		else if (!hold)
		begin
			valid1 <= a.valid && b.valid;
			prod.valid <= valid1;
		end
	end

	// stage one: sign, exponent sum, operand capture
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			sign1 <= a.data.sign ^ b.data.sign;
			exp1 <= a.data.exp + b.data.exp - 16'(expBias);
			zero1 <= !a.data.frac[hiddenPos] || !b.data.frac[hiddenPos];
			fracA1 <= a.data.frac[70:47];
			fracB1 <= b.data.frac[70:47];
		end
	end

	// stage two: product bit 46 lands on the hidden position
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			prod.data.sign <= sign1;
			prod.data.exp <= zero1 ? 16'd0 : exp1;
			prod.data.frac <= zero1 ? 72'd0 : {product, 24'b0};
		end
	end

endmodule

`default_nettype wire

//--- hw/fpOperandIf.sv
`timescale 1ns/1ps
`default_nettype none

interface fpOperandIf;
	import fpFormatPkg::*;

	logic valid;
	fpUnpackedT data;

	modport producer
	(
		output valid,
		output data
	);

	modport consumer
	(
		input valid,
		input data
	);

endinterface

`default_nettype wire

//--- hw/macCtrlPkg.sv
`default_nettype none

package macCtrlPkg;

	typedef logic [1:0] laneIdxT;

	// lane 0 sits in bits 31:0
	typedef fpFormatPkg::fpBits32T [3:0] vecT;

	typedef enum logic [1:0]
	{
		opMulAdd = 2'd0,
		opMulSub = 2'd1,
		opMul = 2'd2
	} macOpT;

	// rides beside the datapath up to the packer
	typedef struct packed
	{
		macOpT op;
		laneIdxT laneDst;
		vecT srcM;
	} macTagT;

endpackage

`default_nettype wire

//--- testbench/fpMacUnit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fpMacUnit_checker (
	input logic clock,
	input logic rst,
	input logic hold,
	input logic inValid,
	input logic resultValid,
	input macCtrlPkg::vecT result
);

	int inFlight; // accepted and not yet taken out

	always_ff @(posedge clock)
	begin
		if (rst)
			inFlight <= 0;
		else if (!hold)
			inFlight <= inFlight + (inValid ? 1 : 0) - (resultValid ? 1 : 0);
	end

	afterReset: assert property (@(posedge clock) rst |=> !resultValid)
		else $error("resultValid high in the cycle after reset");

	holdKeepsValid: assert property (@(posedge clock) disable iff (rst)
		hold |=> $stable(resultValid))
		else $error("resultValid changed while hold was high");

	holdKeepsResult: assert property (@(posedge clock) disable iff (rst)
		hold |=> $stable(result))
		else $error("result changed while hold was high");

	noPhantom: assert property (@(posedge clock) disable iff (rst)
		resultValid |-> inFlight > 0)
		else $error("result without an accepted operation");

endmodule

bind fpMacUnit fpMacUnit_checker fpMacUnit_checker_i (
	.clock(clock),
	.rst(rst),
	.hold(hold),
	.inValid(inValid),
	.resultValid(resultValid),
	.result(result)
);

`default_nettype wire

//--- testbench/fpMacUnit_golden.txt
// op laneSel laneDst srcS srcT srcU srcM expected, all hex
// op 0 mul-add, 1 mul-sub, 2 mul; each vector lists lane 3 first
0 0 0 5555aaaa5555aaaa5555aaaa3fc00000 6666bbbb6666bbbb6666bbbb40000000 7777cccc7777cccc7777cccc3f000000 aaaa0003aaaa0002aaaa0001aaaa0000 aaaa0003aaaa0002aaaa000140600000
0 1 1 5555aaaa5555aaaa3fc000005555aaaa 6666bbbb6666bbbb400000006666bbbb 7777cccc7777cccc3f0000007777cccc aaaa0003aaaa0002aaaa0001aaaa0000 aaaa0003aaaa000240600000aaaa0000
0 2 2 5555aaaa3fc000005555aaaa5555aaaa 6666bbbb400000006666bbbb6666bbbb 7777cccc3f0000007777cccc7777cccc aaaa0003aaaa0002aaaa0001aaaa0000 aaaa000340600000aaaa0001aaaa0000
0 3 3 3fc000005555aaaa5555aaaa5555aaaa 400000006666bbbb6666bbbb6666bbbb 3f0000007777cccc7777cccc7777cccc aaaa0003aaaa0002aaaa0001aaaa0000 40600000aaaa0002aaaa0001aaaa0000
0 0 3 5555aaaa5555aaaa5555aaaa40400000 6666bbbb6666bbbb6666bbbb40000000 7777cccc7777cccc7777cccc3f800000 aaaa0003aaaa0002aaaa0001aaaa0000 40e00000aaaa0002aaaa0001aaaa0000
0 3 0 402000005555aaaa5555aaaa5555aaaa 3f0000006666bbbb6666bbbb6666bbbb 3f4000007777cccc7777cccc7777cccc 0123456789abcdef0f1e2d3c4b5a6978 0123456789abcdef0f1e2d3c40000000
1 1 2 5555aaaa5555aaaa3fc000005555aaaa 6666bbbb6666bbbb400000006666bbbb 7777cccc7777cccc404000007777cccc aaaa0003aaaa0002aaaa0001aaaa0000 aaaa000300000000aaaa0001aaaa0000
1 2 1 5555aaaa3fc000005555aaaa5555aaaa 6666bbbb400000006666bbbb6666bbbb 7777cccc40a000007777cccc7777cccc 13579bdf2468ace0fdb975310eca8642 13579bdf2468ace0c00000000eca8642
2 0 1 5555aaaa5555aaaa5555aaaa40600000 6666bbbb6666bbbb6666bbbbc0000000 7777cccc7777cccc7777cccc42c80000 aaaa0003aaaa0002aaaa0001aaaa0000 aaaa0003aaaa0002c0e00000aaaa0000
1 3 2 408000005555aaaa5555aaaa5555aaaa bf8000006666bbbb6666bbbb6666bbbb c04000007777cccc7777cccc7777cccc 0123456789abcdef0f1e2d3c4b5a6978 01234567bf8000000f1e2d3c4b5a6978
0 0 0 5555aaaa5555aaaa5555aaaa3f800000 6666bbbb6666bbbb6666bbbb3f800000 7777cccc7777cccc7777cccc33c00000 13579bdf2468ace0fdb975310eca8642 13579bdf2468ace0fdb975313f800000
1 1 3 5555aaaa5555aaaabf8000005555aaaa 6666bbbb6666bbbb3f8000006666bbbb 7777cccc7777cccc33c000007777cccc aaaa0003aaaa0002aaaa0001aaaa0000 bf800000aaaa0002aaaa0001aaaa0000
1 2 0 5555aaaa3f8000005555aaaa5555aaaa 6666bbbb3f8000006666bbbb6666bbbb 7777cccc308000007777cccc7777cccc aaaa0003aaaa0002aaaa0001aaaa0000 aaaa0003aaaa0002aaaa00013f7fffff
2 0 2 5555aaaa5555aaaa5555aaaa20000000 6666bbbb6666bbbb6666bbbb20000000 7777cccc7777cccc7777cccc3f800000 aaaa0003aaaa0002aaaa0001aaaa0000 aaaa000300800000aaaa0001aaaa0000
2 1 1 5555aaaa5555aaaa1f8000005555aaaa 6666bbbb6666bbbb200000006666bbbb 7777cccc7777cccc7777cccc7777cccc 0123456789abcdef0f1e2d3c4b5a6978 0123456789abcdef000000004b5a6978
2 2 3 5555aaaa8d8000005555aaaa5555aaaa 6666bbbb0d8000006666bbbb6666bbbb 7777cccc7777cccc7777cccc7777cccc 13579bdf2468ace0fdb975310eca8642 800000002468ace0fdb975310eca8642
2 3 0 718000005555aaaa5555aaaa5555aaaa 718000006666bbbb6666bbbb6666bbbb 7777cccc7777cccc7777cccc7777cccc aaaa0003aaaa0002aaaa0001aaaa0000 aaaa0003aaaa0002aaaa00017f800000
2 0 1 5555aaaa5555aaaa5555aaaaf1800000 6666bbbb6666bbbb6666bbbb71800000 7777cccc7777cccc7777cccc7777cccc aaaa0003aaaa0002aaaa0001aaaa0000 aaaa0003aaaa0002ff800000aaaa0000
2 1 2 5555aaaa5555aaaa7f0000005555aaaa 6666bbbb6666bbbb3f8000006666bbbb 7777cccc7777cccc7777cccc7777cccc 0123456789abcdef0f1e2d3c4b5a6978 012345677f0000000f1e2d3c4b5a6978
2 2 0 5555aaaa7f0000005555aaaa5555aaaa 6666bbbb400000006666bbbb6666bbbb 7777cccc7777cccc7777cccc7777cccc 13579bdf2468ace0fdb975310eca8642 13579bdf2468ace0fdb975317f800000
0 3 1 004000005555aaaa5555aaaa5555aaaa 400000006666bbbb6666bbbb6666bbbb 3f8000007777cccc7777cccc7777cccc aaaa0003aaaa0002aaaa0001aaaa0000 aaaa0003aaaa00023f800000aaaa0000
2 0 3 5555aaaa5555aaaa5555aaaa80400000 6666bbbb6666bbbb6666bbbb40400000 7777cccc7777cccc7777cccc7777cccc 0123456789abcdef0f1e2d3c4b5a6978 0000000089abcdef0f1e2d3c4b5a6978
1 1 0 5555aaaa5555aaaa3f8000005555aaaa 6666bbbb6666bbbb3f8000006666bbbb 7777cccc7777cccc000000017777cccc 13579bdf2468ace0fdb975310eca8642 13579bdf2468ace0fdb975313f800000

//--- testbench/fpMacUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpMacUnit_tb;
	import fpFormatPkg::*;
	import macCtrlPkg::*;

	localparam int maxTests = 64;
	localparam int fieldsPerTest = 8;
	localparam int headerLines = 2; // comment lines ahead of the first test
	localparam int pipeLatency = 7;

	logic clock;
	logic rst;
	logic hold;
	logic inValid;
	macOpT macOp;
	laneIdxT laneSel;
	laneIdxT laneDst;
	vecT srcS;
	vecT srcT;
	vecT srcU;
	vecT srcM;
	logic resultValid;
	vecT result;

	logic [127:0] golden [fieldsPerTest*maxTests];
	int testCount;
	int issued;
	int received;
	int cycleCount;
	int cycleLimit;
	logic [31:0] lfsrState;

	// expected results in issue order
	vecT expectedQ [$];
	int lineQ [$];
	laneIdxT laneQ [$];

	fpMacUnit #(.laneCount(4)) fpMacUnit_i (
		.clock(clock), .rst(rst), .hold(hold), .inValid(inValid),
		.macOp(macOp), .laneSel(laneSel), .laneDst(laneDst),
		.srcS(srcS), .srcT(srcT), .srcU(srcU), .srcM(srcM),
		.resultValid(resultValid), .result(result)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic abortSimulation();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compareLane(input int line, input laneIdxT lane,
		input fpBits32T expected, input fpBits32T actual);
		if (expected !== actual)
		begin
			$display("FAIL golden line %0d: lane %0d expected %h actual %h",
				line, lane, expected, actual);
			abortSimulation();
		end
	endtask

	task automatic compareVec(input int line, input vecT expected, input vecT actual);
		if (expected !== actual)
		begin
			$display("FAIL golden line %0d: result expected %h actual %h",
				line, expected, actual);
			abortSimulation();
		end
	endtask

	task automatic driveTest(input int idx);
		int base;
		base = fieldsPerTest * idx;
		inValid = 1'b1;
		macOp = macOpT'(golden[base][1:0]);
		laneSel = golden[base+1][1:0];
		laneDst = golden[base+2][1:0];
		srcS = golden[base+3];
		srcT = golden[base+4];
		srcU = golden[base+5];
		srcM = golden[base+6];
	endtask

	task automatic recordIssue(input int idx);
		int base;
		base = fieldsPerTest * idx;
		expectedQ.push_back(golden[base+7]);
		laneQ.push_back(golden[base+2][1:0]);
		lineQ.push_back(idx + headerLines + 1);
	endtask

	task automatic checkResult();
		vecT expected;
		laneIdxT lane;
		int line;
		if (expectedQ.size() == 0)
		begin
			$display("a result came out with no operation pending");
			abortSimulation();
		end
		else
		begin
			expected = expectedQ.pop_front();
			lane = laneQ.pop_front();
			line = lineQ.pop_front();
			compareLane(line, lane, expected[lane], result[lane]);
			compareVec(line, expected, result);
			received++;
		end
	endtask

	// a result is taken at the edge that follows with hold low
	initial
	begin
		forever
		begin
			@(negedge clock);
			if (!rst && resultValid && !hold)
				checkResult();
		end
	end

	initial
	begin
		cycleCount = 0;
		@(negedge rst);
		while (cycleCount < cycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout after %0d cycles with %0d of %0d results in",
			cycleCount, received, testCount);
		abortSimulation();
	end

	initial
	begin
		rst = 1'b1;
		hold = 1'b0;
		inValid = 1'b0;
		macOp = opMulAdd;
		laneSel = '0;
		laneDst = '0;
		srcS = '0;
		srcT = '0;
		srcU = '0;
		srcM = '0;
		issued = 0;
		received = 0;
		lfsrState = 32'h6d6d7f69;

		for (int i = 0; i < fieldsPerTest*maxTests; i++)
			golden[i] = {4{~32'(i)}}; // never a legal op code
		$readmemh("testbench/fpMacUnit_golden.txt", golden);
		testCount = 0;
		while (testCount < maxTests && golden[fieldsPerTest*testCount] < 128'd4)
			testCount++;
		cycleLimit = 4 * (testCount + pipeLatency);

		repeat (3) @(posedge clock);
		#2;
		rst = 1'b0;

		if (testCount == 0)
		begin
			$display("no tests found in the golden file");
			abortSimulation();
		end

		while (received < testCount)
		begin
			@(posedge clock);
			#2;
			if (inValid && !hold)
			begin
				recordIssue(issued);
				issued++;
			end
			lfsrState = lfsrNext(lfsrState);
			hold = lfsrState[0];
			if (issued < testCount)
				driveTest(issued);
			else
				inValid = 1'b0;
		end

		// quiet tail catches duplicated results
		@(posedge clock);
		#2;
		hold = 1'b0;
		inValid = 1'b0;
		repeat (8) @(posedge clock);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
